//--- include/alienRow_macros.svh
////////////////////////////////////////////////////////////////////////////
// screen size, alien geometry, colours and game limits
////////////////////////////////////////////////////////////////////////////
`ifndef ALIENROW_MACROS_SVH
`define ALIENROW_MACROS_SVH

`define SCREEN_W 160
`define SCREEN_H 120

`define ALIEN_COUNT 5
`define ALIEN_W 11 // right edge offset, 12 pixels wide
`define ALIEN_H 9 // bottom edge offset, 10 lines
`define ALIEN_PITCH 30
`define ROW_LEFT_X 10
`define ROW_START_Y 10

// left column of alien k
`define ALIEN_LEFT(k) (`ROW_LEFT_X + `ALIEN_PITCH * (k))

`define DROP_STEP 5
`define MAX_DROPS 18 // loss after this many drops

`define ALIEN_COLOUR 3'b010

`endif

//--- hdl/alienRowPkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types for the alien row: coordinates, colour, index, mask, score
////////////////////////////////////////////////////////////////////////////

package alienRowPkg;

	// screen column, 0..159
	typedef logic [7:0] coordX;

	// screen line, 0..119
	typedef logic [6:0] coordY;

	typedef logic [2:0] colour3;

	// alien number 0..4, also used as a counter up to 5
	typedef logic [2:0] alienIndex;

	typedef logic [4:0] alienMask; // bit set while alien alive

	typedef logic [2:0] scoreCount; // kills so far

endpackage

//--- hdl/drawCmdIf.sv
////////////////////////////////////////////////////////////////////////////
// rectangle fill command from the row controller to the pixel painter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface drawCmdIf
	import alienRowPkg::*;
();
	logic start; // one cycle, painter idle
	coordX left;
	coordY top;
	coordX right;
	coordY bottom;
	colour3 fillColour;
	logic done; // one cycle after the last pixel

	modport ctrl (
		output start, left, top, right, bottom, fillColour,
		input done
	);

	modport painter (
		input start, left, top, right, bottom, fillColour,
		output done
	);

endinterface

//--- hdl/targetIf.sv
////////////////////////////////////////////////////////////////////////////
// hit detection link between the row controller and the hit detector
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface targetIf
	import alienRowPkg::*;
();
	logic armed; // level, controller waiting for shots
	coordY rowTop;
	logic consume; // hit taken this cycle

	logic hitValid;
	alienIndex hitIndex;
	alienMask aliveMask;

	modport ctrl (
		output armed, rowTop, consume,
		input hitValid, hitIndex, aliveMask
	);

	modport detector (
		input armed, rowTop, consume,
		output hitValid, hitIndex, aliveMask
	);

endinterface

//--- hdl/hitDetector.sv
////////////////////////////////////////////////////////////////////////////
// shot against alien boxes, lowest live match wins; owns the alive mask
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "alienRow_macros.svh"

module hitDetector
	import alienRowPkg::*;
(
	input logic clk,
	input logic reset,
	input coordX shotX,
	input coordY shotY,
	targetIf.detector tgt
);

	alienMask inColumn;
	alienMask matchMask;
	alienMask aliveMask;
	logic inRow;

	// bounded above and below the row
	assign inRow = (shotY >= tgt.rowTop) && (shotY <= tgt.rowTop + `ALIEN_H);

	always_comb
	begin
		for (int k = 0; k < `ALIEN_COUNT; k++)
			inColumn[k] = (shotX >= `ALIEN_LEFT(k)) && (shotX <= `ALIEN_LEFT(k) + `ALIEN_W);
	end

	assign matchMask = inColumn & aliveMask & {`ALIEN_COUNT{inRow}};
	assign tgt.hitValid = tgt.armed && (matchMask != '0);

	// walk downwards so the lowest set bit is left standing
	always_comb
	begin
		tgt.hitIndex = '0;
		for (int k = `ALIEN_COUNT - 1; k >= 0; k--)
			if (matchMask[k])
				tgt.hitIndex = alienIndex'(k);
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
			aliveMask <= '1; // whole row alive
		else if (tgt.consume)
			aliveMask[tgt.hitIndex] <= 1'b0;
	end

	assign tgt.aliveMask = aliveMask;

	// controller may only take a hit that is being reported
	consumeNeedsHit: assert property (@(posedge clk) disable iff (!reset)
		tgt.consume |-> tgt.hitValid)
		else $error("consume without a valid hit");

endmodule

//--- hdl/dropTimer.sv
////////////////////////////////////////////////////////////////////////////
// cycles to the next row drop, and the count of drops made
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "alienRow_macros.svh"

module dropTimer #(
	parameter int dropPeriod = 1000
)
(
	input logic clk,
	input logic reset,
	input logic dropDone,
	output logic drop,
	output logic bottomReached
);

	localparam int countW = (dropPeriod > 1) ? $clog2(dropPeriod) : 1;
	localparam int dropW = $clog2(`MAX_DROPS + 1);

	logic [countW-1:0] count;
	logic [dropW-1:0] dropCount;
	logic atZero;
	logic wasZero; // zero already seen last cycle

	assign atZero = (count == '0);
	assign drop = atZero && !wasZero; // first cycle at zero only
	assign bottomReached = (dropCount == dropW'(`MAX_DROPS));

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			count <= countW'(dropPeriod - 1);
			wasZero <= 1'b0;
			dropCount <= '0;
		end
		else
		begin
			wasZero <= atZero && !dropDone;
			if (dropDone)
			begin
				count <= countW'(dropPeriod - 1); // restart
				if (!bottomReached)
					dropCount <= dropCount + 1'b1;
			end
			else if (!atZero)
				count <= count - 1'b1; // parks at zero until acknowledged
		end
	end

	ackAfterDrop: assert property (@(posedge clk) disable iff (!reset)
		dropDone |-> (atZero && wasZero))
		else $error("drop acknowledged before it was raised");

endmodule

//--- hdl/rowController.sv
////////////////////////////////////////////////////////////////////////////
// game FSM: row painting, hit erase, timed drop, score and end of game
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "alienRow_macros.svh"

module rowController
	import alienRowPkg::*;
(
	input logic clk,
	input logic reset,
	input logic drop,
	input logic bottomReached,
	output logic dropDone,
	output logic hit,
	output scoreCount score,
	output logic gameOver,
	output logic gameWon,
	targetIf.ctrl tgt,
	drawCmdIf.ctrl cmd
);

	typedef enum logic [2:0] {
		paintRow,
		armedWait,
		eraseAlien,
		eraseBand,
		lost,
		won
	} rowState;

	rowState state;
	coordY rowTop;
	logic dropPending;
	alienIndex alienCtr; // next alien to paint
	logic cmdBusy; // fill issued, done not yet seen
	alienMask shiftedMask;
	logic ctrLive;
	logic takeDrop;
	logic paintIssue;
	logic bandIssue;
	logic issue;
	coordX nextLeft;
	coordX nextRight;
	colour3 nextColour;

	assign shiftedMask = tgt.aliveMask >> alienCtr;
	assign ctrLive = shiftedMask[0];

	assign takeDrop = dropPending || drop;
	assign tgt.armed = (state == armedWait);
	assign tgt.rowTop = rowTop;
	// bottom first, then drop, then hit
	assign tgt.consume = tgt.armed && tgt.hitValid && !bottomReached && !takeDrop;

	assign paintIssue = (state == paintRow) && !cmdBusy &&
		(alienCtr != alienIndex'(`ALIEN_COUNT)) && ctrLive;
	assign bandIssue = tgt.armed && !bottomReached && takeDrop;
	assign issue = paintIssue || bandIssue || tgt.consume;

	// rectangle for whichever fill goes out this cycle
	always_comb
	begin
		nextLeft = coordX'(`ALIEN_LEFT(alienCtr));
		nextColour = `ALIEN_COLOUR;
		if (bandIssue)
		begin
			nextLeft = '0;
			nextColour = '0;
		end
		else if (tgt.consume)
		begin
			nextLeft = coordX'(`ALIEN_LEFT(tgt.hitIndex));
			nextColour = '0;
		end
		nextRight = bandIssue ? coordX'(`SCREEN_W - 1) : coordX'(nextLeft + `ALIEN_W);
	end

	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			cmd.left <= nextLeft;
			cmd.top <= rowTop;
			cmd.right <= nextRight;
			cmd.bottom <= coordY'(rowTop + `ALIEN_H);
			cmd.fillColour <= nextColour;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			state <= paintRow;
			rowTop <= coordY'(`ROW_START_Y);
			dropPending <= 1'b0;
			alienCtr <= '0;
			cmdBusy <= 1'b0;
			cmd.start <= 1'b0;
			score <= '0;
			hit <= 1'b0;
			dropDone <= 1'b0;
			gameOver <= 1'b0;
			gameWon <= 1'b0;
		end
		else
		begin
			cmd.start <= issue;
			hit <= 1'b0;
			dropDone <= 1'b0;
			if (drop)
				dropPending <= 1'b1; // held until armed again
			if (issue)
				cmdBusy <= 1'b1;
			else if (cmd.done)
				cmdBusy <= 1'b0;

			case (state)
				paintRow:
				begin
					if (cmd.done)
						alienCtr <= alienCtr + 1'b1;
					else if (!cmdBusy)
					begin
						if (alienCtr == alienIndex'(`ALIEN_COUNT))
							state <= armedWait;
						else if (!ctrLive)
							alienCtr <= alienCtr + 1'b1; // skip dead alien
					end
				end
				armedWait:
				begin
					if (bottomReached)
					begin
						state <= lost;
						gameOver <= 1'b1;
					end
					else if (takeDrop)
					begin
						state <= eraseBand;
						dropPending <= 1'b0;
						dropDone <= 1'b1;
					end
					else if (tgt.consume)
					begin
						state <= eraseAlien;
						hit <= 1'b1;
						score <= score + 1'b1;
					end
				end
				eraseAlien:
				begin
					if (cmd.done)
					begin
						if (score == scoreCount'(`ALIEN_COUNT))
						begin
							state <= won;
							gameWon <= 1'b1;
						end
						else
							state <= armedWait;
					end
				end
				eraseBand:
				begin
					if (cmd.done)
					begin
						rowTop <= rowTop + coordY'(`DROP_STEP);
						alienCtr <= '0;
						state <= paintRow; // survivors at the new top
					end
				end
				lost, won:
					state <= state;
				default:
					state <= paintRow;
			endcase
		end
	end

	property startWaitsForDone;
		@(posedge clk) disable iff (!reset)
		cmd.start |=> (!cmd.start throughout cmd.done[->1]);
	endproperty

	noOverlappingStart: assert property (startWaitsForDone)
		else $error("fill command issued while one is outstanding");

	// the dropped row still has to fit
	rowOnScreen: assert property (@(posedge clk) disable iff (!reset)
		(state == eraseBand) |-> (rowTop + `ALIEN_H + `DROP_STEP < `SCREEN_H))
		else $error("row would drop off the screen");

endmodule

//--- hdl/pixelPainter.sv
////////////////////////////////////////////////////////////////////////////
// rectangle fill, one pixel per cycle in raster order
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pixelPainter
	import alienRowPkg::*;
(
	input logic clk,
	input logic reset,
	drawCmdIf.painter cmd,
	output coordX pixelX,
	output coordY pixelY,
	output colour3 pixelColour,
	output logic drawEn
);

	coordX rectLeft;
	coordX rectRight;
	coordY rectBottom;
	logic rowEnd;
	logic lastPixel;

	assign rowEnd = (pixelX == rectRight);
	assign lastPixel = rowEnd && (pixelY == rectBottom);

	// control: busy flag and done strobe
	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			drawEn <= 1'b0;
			cmd.done <= 1'b0;
		end
		else
		begin
			cmd.done <= drawEn && lastPixel;
			if (cmd.start)
				drawEn <= 1'b1;
			else if (lastPixel)
				drawEn <= 1'b0;
		end
	end

	// pixel walk, x then y
	always_ff @(posedge clk)
	begin
		if (cmd.start)
		begin
			rectLeft <= cmd.left;
			rectRight <= cmd.right;
			rectBottom <= cmd.bottom;
			pixelX <= cmd.left; // first pixel
			pixelY <= cmd.top;
			pixelColour <= cmd.fillColour;
		end
		else if (drawEn && !lastPixel)
		begin
			if (rowEnd)
			begin
				pixelX <= rectLeft;
				pixelY <= pixelY + 1'b1;
			end
			else
				pixelX <= pixelX + 1'b1;
		end
	end

	startWhileIdle: assert property (@(posedge clk) disable iff (!reset)
		cmd.start |-> !drawEn)
		else $error("fill started while painter busy");

endmodule

//--- hdl/alienRow.sv
////////////////////////////////////////////////////////////////////////////
// alien row top level, detector, timer, controller and painter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module alienRow
	import alienRowPkg::*;
#(
	parameter int dropPeriod = 1000 // cycles between drops
)
(
	input logic clk,
	input logic reset,
	input coordX shotX,
	input coordY shotY,
	output coordX pixelX,
	output coordY pixelY,
	output colour3 pixelColour,
	output logic drawEn,
	output logic hit,
	output scoreCount score,
	output logic gameOver,
	output logic gameWon
);

	logic drop;
	logic dropDone;
	logic bottomReached;

	targetIf tgt ();
	drawCmdIf cmd ();

	hitDetector uHitDetector (
		.clk(clk),
		.reset(reset),
		.shotX(shotX),
		.shotY(shotY),
		.tgt(tgt.detector)
	);

	dropTimer #(
		.dropPeriod(dropPeriod)
	) uDropTimer (
		.clk(clk),
		.reset(reset),
		.dropDone(dropDone),
		.drop(drop),
		.bottomReached(bottomReached)
	);

	rowController uRowController (
		.clk(clk),
		.reset(reset),
		.drop(drop),
		.bottomReached(bottomReached),
		.dropDone(dropDone),
		.hit(hit),
		.score(score),
		.gameOver(gameOver),
		.gameWon(gameWon),
		.tgt(tgt.ctrl),
		.cmd(cmd.ctrl)
	);

	pixelPainter uPixelPainter (
		.clk(clk),
		.reset(reset),
		.cmd(cmd.painter),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelColour(pixelColour),
		.drawEn(drawEn)
	);

endmodule

//--- test/clockGen.sv
////////////////////////////////////////////////////////////////////////////
// testbench clock, 4 ns period, and synchronous active low reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic reset,
	input logic resetReq
);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// reset held for 10 rising edges, again on every request
	initial
	begin
		reset = 1'b0;
		forever
		begin
			repeat (10) @(posedge clk);
			#1 reset = 1'b1; // released just after the edge
			@(posedge resetReq);
			reset = 1'b0;
		end
	end

endmodule

//--- test/alienRowTb.sv
////////////////////////////////////////////////////////////////////////////
// alien row testbench: shot table, pixel reference model, win and loss games
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "alienRow_macros.svh"

module alienRowTb
	import alienRowPkg::*;
();

	localparam int dropPeriod = 3000;
	localparam int tableLen = 11;
	localparam int armDelay = 8; // quiet cycles before a shot
	localparam int dropMargin = 300; // keep shots clear of the next drop
	localparam int cycleLimit = tableLen * (dropPeriod + 400) +
		(`MAX_DROPS + 2) * (dropPeriod + 1);

	logic clk;
	logic reset;
	logic resetReq;
	coordX shotX;
	coordY shotY;
	coordX pixelX;
	coordY pixelY;
	colour3 pixelColour;
	logic drawEn;
	logic hit;
	scoreCount score;
	logic gameOver;
	logic gameWon;

	// shot table, line given relative to the row top
	int tabX [tableLen];
	int tabDy [tableLen];
	bit tabWaitDrop [tableLen];
	bit tabHit [tableLen];
	int tabIndex [tableLen];
	int tabWait [tableLen];
	int tabCount = 0;

	// reference model: fills still to be drawn, in order
	int rectLeft [$];
	int rectTop [$];
	int rectRight [$];
	int rectBottom [$];
	int rectColour [$];
	int pixIndex;
	alienMask modelMask;
	int modelRowTop;
	int modelScore;
	int modelDrops;
	bit modelWon;
	int sinceDrop;

	int errors = 0;
	int cycles = 0;
	int hitsSeen = 0;
	int alienPixels = 0;
	int blackPixels = 0;
	integer seed = 46;

	clockGen clockGen (
		.clk(clk),
		.reset(reset),
		.resetReq(resetReq)
	);

	alienRow #(
		.dropPeriod(dropPeriod)
	) UUT (
		.clk(clk),
		.reset(reset),
		.shotX(shotX),
		.shotY(shotY),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelColour(pixelColour),
		.drawEn(drawEn),
		.hit(hit),
		.score(score),
		.gameOver(gameOver),
		.gameWon(gameWon)
	);

	task automatic checkValue(input string name, input logic [31:0] got, input int expected);
		assert (got === expected)
		else
		begin
			errors++;
			$display("Fail %0t %s got %0d expected %0d", $time, name, got, expected);
		end
	endtask

	task automatic addEntry(input int x, input int dy, input bit waitDrop,
		input bit expHit, input int expIndex, input int waitAfter);
		tabX[tabCount] = x;
		tabDy[tabCount] = dy;
		tabWaitDrop[tabCount] = waitDrop;
		tabHit[tabCount] = expHit;
		tabIndex[tabCount] = expIndex;
		tabWait[tabCount] = waitAfter;
		tabCount++;
	endtask

	task automatic buildTable();
		addEntry(15, 4, 0, 1, 0, 10);
		addEntry(15, 4, 0, 0, 0, 10); // alien 0 already dead
		addEntry(30, 2, 0, 0, 0, 10); // gap column
		addEntry(45, 10, 0, 0, 0, 10); // one line below the row
		addEntry(45, -1, 0, 0, 0, 10); // one line above
		addEntry(51, 9, 0, 1, 1, 20); // bottom right corner of alien 1
		addEntry(70, 0, 1, 1, 2, 20); // first shot after a drop
		addEntry(100, -3, 0, 0, 0, 10); // inside the old band
		addEntry(111, 0, 0, 1, 3, 10);
		addEntry(140, 12, 0, 0, 0, 10);
		addEntry(130, 5, 0, 1, 4, 10); // last alien, game won
	endtask

	task automatic pushRect(input int left, input int top, input int right,
		input int bottom, input int colour);
		rectLeft.push_back(left);
		rectTop.push_back(top);
		rectRight.push_back(right);
		rectBottom.push_back(bottom);
		rectColour.push_back(colour);
	endtask

	task automatic pushAlien(input int k, input int colour);
		pushRect(`ALIEN_LEFT(k), modelRowTop, `ALIEN_LEFT(k) + `ALIEN_W,
			modelRowTop + `ALIEN_H, colour);
	endtask

	task automatic resetModel();
		rectLeft.delete();
		rectTop.delete();
		rectRight.delete();
		rectBottom.delete();
		rectColour.delete();
		pixIndex = 0;
		modelMask = '1;
		modelRowTop = `ROW_START_Y;
		modelScore = 0;
		modelDrops = 0;
		modelWon = 0;
		sinceDrop = 0;
		for (int k = 0; k < `ALIEN_COUNT; k++)
			pushAlien(k, `ALIEN_COLOUR);
	endtask

	// old band black, then the survivors one step lower
	task automatic modelDrop();
		pushRect(0, modelRowTop, `SCREEN_W - 1, modelRowTop + `ALIEN_H, 0);
		modelRowTop += `DROP_STEP;
		for (int k = 0; k < `ALIEN_COUNT; k++)
			if (modelMask[k])
				pushAlien(k, `ALIEN_COLOUR);
		modelDrops++;
		sinceDrop = -1; // next drop one period plus the acknowledge later
	endtask

	task automatic checkPixel();
		int w;
		int h;
		int expX;
		int expY;
		assert (rectLeft.size() != 0)
		else
		begin
			errors++;
			$display("pixel drawn at %0t while no fill was expected", $time);
		end
		if (rectLeft.size() != 0)
		begin
			w = rectRight[0] - rectLeft[0] + 1;
			h = rectBottom[0] - rectTop[0] + 1;
			expX = rectLeft[0] + pixIndex % w; // raster order
			expY = rectTop[0] + pixIndex / w;
			checkValue("pixelX", pixelX, expX);
			checkValue("pixelY", pixelY, expY);
			checkValue("pixelColour", pixelColour, rectColour[0]);
			if (pixelColour == '0)
				blackPixels++;
			else
				alienPixels++;
			pixIndex++;
			if (pixIndex == w * h)
			begin
				void'(rectLeft.pop_front());
				void'(rectTop.pop_front());
				void'(rectRight.pop_front());
				void'(rectBottom.pop_front());
				void'(rectColour.pop_front());
				pixIndex = 0;
			end
		end
	endtask

	// outputs are registered, so sample on the falling edge
	always @(negedge clk)
	begin
		if (!reset)
			resetModel();
		else
		begin
			sinceDrop++;
			if (sinceDrop == dropPeriod && !modelWon && modelDrops < `MAX_DROPS)
				modelDrop();
			if (drawEn)
				checkPixel();
			if (hit)
				hitsSeen++;
			assert (!gameOver || modelDrops == `MAX_DROPS)
			else
			begin
				errors++;
				$display("gameOver high at %0t before the row reached the bottom", $time);
			end
			assert (!gameWon || modelWon)
			else
			begin
				errors++;
				$display("gameWon high at %0t with aliens still alive", $time);
			end
		end
	end

	task automatic printCounts();
		$display("errors %0d, alien pixels %0d, black pixels %0d, hit pulses %0d",
			errors, alienPixels, blackPixels, hitsSeen);
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycleLimit)
		begin
			$display("run stopped after %0d cycles without reaching the end", cycles);
			printCounts();
			$display("Checks failed");
			$finish;
		end
	end

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	// miss shot somewhere in the gaps between aliens
	task automatic randomGapShot();
		int gap;
		gap = $unsigned($random(seed)) % 4;
		shotX = coordX'(`ALIEN_LEFT(gap) + `ALIEN_W + 1 +
			$unsigned($random(seed)) % (`ALIEN_PITCH - `ALIEN_W - 1));
		shotY = coordY'(modelRowTop + $unsigned($random(seed)) % 10);
	endtask

	// nothing left to draw and no drop close, for a few cycles in a row
	task automatic waitSafe();
		int quiet;
		quiet = 0;
		while (quiet < armDelay)
		begin
			nextCycle();
			if (rectLeft.size() == 0 && sinceDrop >= 0 &&
				sinceDrop < dropPeriod - dropMargin)
				quiet++;
			else
				quiet = 0;
		end
	endtask

	task automatic applyEntry(input int i);
		int dropsBefore;
		dropsBefore = modelDrops;
		if (tabWaitDrop[i])
			while (modelDrops == dropsBefore)
				nextCycle();
		waitSafe();
		shotX = coordX'(tabX[i]);
		shotY = coordY'(modelRowTop + tabDy[i]);
		if (tabHit[i])
		begin
			modelMask[tabIndex[i]] = 1'b0;
			modelScore++;
			modelWon = (modelScore == `ALIEN_COUNT);
			pushAlien(tabIndex[i], 0); // erase box
		end
		nextCycle();
		checkValue("hit", hit, tabHit[i]);
		checkValue("score", score, modelScore);
		nextCycle();
		checkValue("hit", hit, 0); // single cycle pulse
		randomGapShot();
		repeat (tabWait[i])
			nextCycle();
	endtask

	task automatic checkIdle();
		checkValue("drawEn", drawEn, 0);
		checkValue("hit", hit, 0);
		checkValue("gameOver", gameOver, 0);
		checkValue("gameWon", gameWon, 0);
		checkValue("score", score, 0);
	endtask

	initial
	begin
		shotX = '0;
		shotY = '0;
		resetReq = 1'b0;
		buildTable();
		@(posedge reset);
		nextCycle();
		checkIdle();

		for (int i = 0; i < tableLen; i++)
			applyEntry(i);
		while (rectLeft.size() != 0)
			nextCycle();
		repeat (armDelay) nextCycle();
		checkValue("gameWon", gameWon, 1);
		checkValue("score", score, `ALIEN_COUNT);
		checkValue("gameOver", gameOver, 0);
		repeat (200) nextCycle();
		checkValue("gameWon", gameWon, 1);

		// second game, no hits until the row is at the bottom
		resetReq = 1'b1;
		nextCycle();
		resetReq = 1'b0;
		@(posedge reset);
		nextCycle();
		checkIdle();
		while (!gameOver)
		begin
			nextCycle();
			if (cycles % 256 == 0)
				randomGapShot();
		end
		assert (rectLeft.size() == 0 && modelDrops == `MAX_DROPS)
		else
		begin
			errors++;
			$display("gameOver rose at %0t after %0d drops with fills still due",
				$time, modelDrops);
		end
		checkValue("gameWon", gameWon, 0);
		checkValue("score", score, 0);
		repeat (200) nextCycle();
		checkValue("gameOver", gameOver, 1);
		checkValue("hit pulses", hitsSeen, `ALIEN_COUNT);

		printCounts();
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+include
hdl/alienRowPkg.sv
hdl/drawCmdIf.sv
hdl/targetIf.sv
hdl/hitDetector.sv
hdl/dropTimer.sv
hdl/rowController.sv
hdl/pixelPainter.sv
hdl/alienRow.sv
test/clockGen.sv
test/alienRowTb.sv

//--- Bender.yml
package:
  name: alienRow

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/alienRowPkg.sv
      - hdl/drawCmdIf.sv
      - hdl/targetIf.sv
      - hdl/hitDetector.sv
      - hdl/dropTimer.sv
      - hdl/rowController.sv
      - hdl/pixelPainter.sv
      - hdl/alienRow.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/clockGen.sv
      - test/alienRowTb.sv
